/* Bender.yml */
package:
  name: softermax_norm

sources:
  - logic/softermax_pkg.sv
  - logic/skid_buffer.sv
  - logic/fixed_range_reduction.sv
  - logic/softermax_lpw_reciprocal.sv
  - logic/norm_controller.sv
  - logic/elem_counter.sv
  - logic/norm_datapath.sv
  - logic/softermax_norm_top.sv
  - target: simulation
    files:
      - bench/tb_softermax_norm.sv

/* bench/tb_softermax_norm.sv */
// Testbench for the softermax normalization back end
// Stimulus table with expected beats from a bit-exact model
// Galois LFSR back-pressure on the output stream
// Value checker, stream monitor and watchdog
`timescale 1ns/1ps

module tb_softermax_norm import softermax_pkg::*; ();

  localparam int NUM_VECS       = 19;
  localparam int NUM_BEATS      = NUM_VECS * VEC_LEN;
  localparam int SEGMENTS       = 8;
  localparam int TIMEOUT_CYCLES = NUM_BEATS * 40 + 200;

  logic       clk;
  logic       reset;
  elem_t      in_data;
  logic       in_valid;
  logic       in_ready;
  norm_beat_t out_data;
  logic       out_valid;
  logic       out_ready;

  logic [15:0] lfsr_state;
  int          error_count;
  int          beat_count;
  int          slope_tab [SEGMENTS];
  int          icpt_tab  [SEGMENTS];
  norm_beat_t  exp_beats [NUM_BEATS];

  // Element 0 in the top byte
  logic [VEC_LEN*ELEM_WIDTH-1:0] stim_table [NUM_VECS] = '{
    32'h00_00_00_00,  // all zeros, 1/0 saturates
    32'h01_00_00_00,  // sum 1, msb 0
    32'h00_10_00_00,  // single 1.0, msb 4 segment 0
    32'h01_01_01_00,
    32'h02_01_02_02,  // msb 2 segment 6
    32'h03_04_02_03,
    32'h05_06_07_08,
    32'h10_08_0c_0a,
    32'h11_22_04_08,  // msb 5 segment 7
    32'h20_18_10_0c,
    32'h40_30_20_08,  // segment 1
    32'h80_40_20_10,
    32'h90_a0_50_28,
    32'hff_ff_ff_ff,  // largest sum
    32'hc0_80_60_20,
    32'hff_01_00_00,
    32'h7f_7f_7f_7f,
    32'hf0_c8_a0_78,  // msb 9 segment 3
    32'h00_00_00_a5   // single non-zero in the last slot
  };

  softermax_norm_top dut (
    .clk      (clk),
    .reset    (reset),
    .in_data  (in_data),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_data (out_data),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hb400;
    end
    return n;
  endfunction

  function automatic elem_t elem_of(int v, int j);
    return stim_table[v][(VEC_LEN-1-j)*ELEM_WIDTH +: ELEM_WIDTH];
  endfunction

  // Chord of 1/x on each segment of [1, 2): slope -1/(x1*x2), intercept 1/x1 + 1/x2
  task automatic build_tables();
    real x1;
    real x2;
    for (int i = 0; i < SEGMENTS; i++) begin
      x1 = 1.0 + real'(i) / SEGMENTS;
      x2 = 1.0 + real'(i + 1) / SEGMENTS;
      slope_tab[i] = int'(-(2.0 ** SLOPE_FRAC_WIDTH) / (x1 * x2));
      icpt_tab[i]  = int'((1.0 / x1 + 1.0 / x2) * (2.0 ** MULT_FRAC_WIDTH));
    end
  endtask

  function automatic int recip_model(int sum);
    int     msb;
    int     mant;
    int     seg;
    longint lpw;
    longint scaled;
    longint fl;
    if (sum == 0) begin
      return RECIP_MAX;
    end
    msb = 0;
    for (int i = 0; i < SUM_WIDTH; i++) begin
      if ((sum >> i) & 1) begin
        msb = i;
      end
    end
    // Mantissa in [1, 2) with nine fraction bits
    mant = sum << (MANT_FRAC_WIDTH - msb);
    seg  = (mant >> (MANT_FRAC_WIDTH - 3)) & (SEGMENTS - 1);
    lpw  = longint'(mant) * slope_tab[seg] + icpt_tab[seg];
    if (msb <= SUM_FRAC_WIDTH) begin
      scaled = lpw << (SUM_FRAC_WIDTH - msb);
    end else begin
      scaled = lpw >>> (msb - SUM_FRAC_WIDTH);
    end
    fl = scaled >>> (MULT_FRAC_WIDTH - RECIP_FRAC_WIDTH);
    if (fl > RECIP_MAX) begin
      return RECIP_MAX;
    end else if (fl < 0) begin
      return 0;
    end
    return int'(fl);
  endfunction

  function automatic int prob_model(int elem, int recip);
    int p;
    p = (elem * recip) >> (ELEM_FRAC_WIDTH + RECIP_FRAC_WIDTH - PROB_FRAC_WIDTH);
    return (p > PROB_MAX) ? PROB_MAX : p;
  endfunction

  task automatic build_expected();
    int sum;
    int recip;
    for (int v = 0; v < NUM_VECS; v++) begin
      sum = 0;
      for (int j = 0; j < VEC_LEN; j++) begin
        sum += elem_of(v, j);
      end
      recip = recip_model(sum);
      for (int j = 0; j < VEC_LEN; j++) begin
        exp_beats[v*VEC_LEN+j].prob = prob_t'(prob_model(elem_of(v, j), recip));
        exp_beats[v*VEC_LEN+j].last = (j == VEC_LEN - 1);
      end
    end
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("Fail %s: got 0x%0h, expected 0x%0h (beat %0d)", name, got, exp, beat_count);
    end
  endtask

  // Hold the element until the FSM takes it
  task automatic send_elem(elem_t v);
    @(negedge clk);
    in_data  = v;
    in_valid = 1'b1;
    while (!in_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  // Output side: random ready, protocol checks, beat compare
  always @(negedge clk) begin
    out_ready  = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
    if (reset) begin
      if (out_valid !== 1'b0) begin
        error_count++;
        $display("out_valid is not low during reset");
      end
    end else begin
      if (out_valid && in_ready) begin
        error_count++;
        $display("in_ready and out_valid are high in the same cycle");
      end
      // Beat is taken at the next rising edge
      if (out_valid && out_ready) begin
        if (beat_count >= NUM_BEATS) begin
          error_count++;
          $display("Extra output beat after all expected beats were seen");
        end else begin
          check_value("out_data.prob", out_data.prob, exp_beats[beat_count].prob);
          check_value("out_data.last", out_data.last, exp_beats[beat_count].last);
        end
        beat_count++;
      end
    end
  end

  initial begin
    reset       = 1'b1;
    in_data     = '0;
    in_valid    = 1'b0;
    out_ready   = 1'b0;
    lfsr_state  = 16'd27;
    error_count = 0;
    beat_count  = 0;
    build_tables();
    build_expected();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int v = 0; v < NUM_VECS; v++) begin
      for (int j = 0; j < VEC_LEN; j++) begin
        send_elem(elem_of(v, j));
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    while (beat_count < NUM_BEATS) begin
      @(negedge clk);
    end
    // Time for a stray extra beat to show up
    repeat (20) @(negedge clk);
    $display("Errors: %0d, beats seen: %0d of %0d", error_count, beat_count, NUM_BEATS);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: output stream stalled after %0d of %0d beats", beat_count, NUM_BEATS);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* flist.f */
logic/softermax_pkg.sv
logic/skid_buffer.sv
logic/fixed_range_reduction.sv
logic/softermax_lpw_reciprocal.sv
logic/norm_controller.sv
logic/elem_counter.sv
logic/norm_datapath.sv
logic/softermax_norm_top.sv
bench/tb_softermax_norm.sv

/* logic/elem_counter.sv */
// Element index counter, wraps at the vector length
// Flags the last element of a vector
`timescale 1ns/1ps

module elem_counter import softermax_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 count_en,
  output logic [IDX_WIDTH-1:0] index,
  output logic                 last
);

  assign last = (index == IDX_WIDTH'(VEC_LEN - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      index <= '0;
    end else if (count_en) begin
      index <= last ? '0 : index + 1'b1;
    end
  end

endmodule

/* logic/fixed_range_reduction.sv */
// Leading-one finder for the vector sum
// Left-aligns the sum into a Q1.9 mantissa in [1, 2)
// Reports the MSB index and a zero flag
`timescale 1ns/1ps

module fixed_range_reduction import softermax_pkg::*; (
  input  sum_t           data_in,
  output range_reduced_t data_out
);

  logic [MSB_WIDTH-1:0] msb;
  logic                 found;

  always_comb begin
    msb   = '0;
    found = 1'b0;
    // Highest set bit wins
    for (int i = 0; i < SUM_WIDTH; i++) begin
      if (data_in[i]) begin
        msb   = MSB_WIDTH'(i);
        found = 1'b1;
      end
    end
    data_out.mant = data_in << (SUM_WIDTH - 1 - msb);
    data_out.msb  = msb;
    data_out.zero = !found;
  end

endmodule

/* logic/norm_controller.sv */
// Normalization FSM: accumulate, request reciprocal, wait, scale
// Drives the stream handshakes and the datapath strobes
// Checks on the reciprocal request and response
`timescale 1ns/1ps

module norm_controller import softermax_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic in_valid,
  output logic in_ready,
  output logic out_valid,
  input  logic out_ready,
  input  logic last,
  output logic count_en,
  output logic accept_elem,
  output logic clear_sum,
  output logic load_recip,
  output logic recip_in_valid,
  input  logic recip_in_ready,
  input  logic recip_out_valid,
  output logic recip_out_ready
);

  norm_state_e state_q, state_d;
  logic        in_fire;
  logic        out_fire;

  assign in_ready        = (state_q == ACCUM);
  assign out_valid       = (state_q == SCALE);
  assign recip_in_valid  = (state_q == RECIP_REQ);
  assign recip_out_ready = (state_q == RECIP_WAIT);

  assign in_fire     = in_valid && in_ready;
  assign out_fire    = out_valid && out_ready;
  assign accept_elem = in_fire;
  // One counter serves both the input and the output phase
  assign count_en    = in_fire || out_fire;
  assign load_recip  = recip_out_valid && recip_out_ready;
  assign clear_sum   = out_fire && last;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ACCUM:      if (in_fire && last) state_d = RECIP_REQ;
      RECIP_REQ:  if (recip_in_ready) state_d = RECIP_WAIT;
      RECIP_WAIT: if (recip_out_valid) state_d = SCALE;
      SCALE:      if (out_fire && last) state_d = ACCUM;
      default:    state_d = ACCUM;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ACCUM;
    end else begin
      state_q <= state_d;
    end
  end

  // Empty pipeline takes a request at once
  a_req_taken: assert property (@(posedge clk) disable iff (reset)
    recip_in_valid |-> recip_in_ready);

  // Pipeline holds a single item, so a result only shows up while waiting
  a_resp_in_wait: assert property (@(posedge clk) disable iff (reset)
    recip_out_valid |-> state_q == RECIP_WAIT);

endmodule

/* logic/norm_datapath.sv */
// Element buffer and sum accumulator for one vector
// Reciprocal holding register
// Scaling multiplier with floor and saturate to Q1.7
`timescale 1ns/1ps

module norm_datapath import softermax_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  elem_t                in_data,
  input  logic                 accept_elem,
  input  logic                 clear_sum,
  input  logic                 load_recip,
  input  logic [IDX_WIDTH-1:0] index,
  input  logic                 last,
  output sum_t                 recip_in_data,
  input  recip_t               recip_out_data,
  output norm_beat_t           out_data
);

  localparam int PROD_WIDTH = ELEM_WIDTH + RECIP_WIDTH;

  elem_t                 elem_buf [VEC_LEN];
  sum_t                  sum_q;
  recip_t                recip_q;
  logic [PROD_WIDTH-1:0] product;
  logic [PROD_WIDTH-1:0] floored;

  always_ff @(posedge clk) begin
    if (reset || clear_sum) begin
      sum_q <= '0;
    end else if (accept_elem) begin
      sum_q <= sum_q + SUM_WIDTH'(in_data);
    end
  end

  always_ff @(posedge clk) begin
    if (accept_elem) begin
      elem_buf[index] <= in_data;
    end
    if (load_recip) begin
      recip_q <= recip_out_data;
    end
  end

  assign recip_in_data = sum_q;

  // Q4.4 times Q1.7 gives Q5.11, keep seven fraction bits
  assign product = elem_buf[index] * recip_q;
  assign floored = product >> (ELEM_FRAC_WIDTH + RECIP_FRAC_WIDTH - PROB_FRAC_WIDTH);

  assign out_data.prob = (floored > PROB_MAX) ? '1 : floored[PROB_WIDTH-1:0];
  assign out_data.last = last;

endmodule

/* logic/skid_buffer.sv */
// Registered valid/ready pipeline stage
// Main output register plus one skid register, full throughput
// Output stability check under back-pressure
`timescale 1ns/1ps

module skid_buffer #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [DATA_WIDTH-1:0] data_in,
  input  logic                  data_in_valid,
  output logic                  data_in_ready,
  output logic [DATA_WIDTH-1:0] data_out,
  output logic                  data_out_valid,
  input  logic                  data_out_ready
);

  logic [DATA_WIDTH-1:0] main_q;
  logic [DATA_WIDTH-1:0] skid_q;
  logic                  main_valid_q;
  logic                  skid_valid_q;
  logic                  in_fire;
  logic                  load_main;

  assign data_in_ready  = !skid_valid_q;
  assign data_out       = main_q;
  assign data_out_valid = main_valid_q;
  assign in_fire        = data_in_valid && data_in_ready;
  // Main register free or being drained this cycle
  assign load_main      = !main_valid_q || data_out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (load_main) begin
      main_valid_q <= skid_valid_q || in_fire;
      skid_valid_q <= 1'b0;
    end else if (in_fire) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load_main) begin
      main_q <= skid_valid_q ? skid_q : data_in;
    end else if (in_fire) begin
      skid_q <= data_in;
    end
  end

  a_hold_stable: assert property (@(posedge clk) disable iff (reset)
    data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out));

endmodule

/* logic/softermax_lpw_reciprocal.sv */
// Pipelined 1/x by linear piecewise approximation over [1, 2)
// Slope and intercept tables built from chords of 1/x
// Stages: range reduce, multiply, add intercept, shift back,
// floor and saturate to Q1.7
// Zero input returns all ones
`timescale 1ns/1ps

module softermax_lpw_reciprocal import softermax_pkg::*; #(
  parameter int ENTRIES = 8
) (
  input  logic   clk,
  input  logic   reset,
  input  sum_t   in_data,
  input  logic   in_valid,
  output logic   in_ready,
  output recip_t out_data,
  output logic   out_valid,
  input  logic   out_ready
);

  localparam int ENTRIES_WIDTH = $clog2(ENTRIES);

  typedef logic signed [SLOPE_WIDTH-1:0] slope_t;
  typedef logic [INTERCEPT_WIDTH-1:0]    intercept_t;

  typedef struct packed {
    logic signed [MULT_WIDTH-1:0] mult;
    logic [ENTRIES_WIDTH-1:0]     seg;
    logic [MSB_WIDTH-1:0]         msb;
    logic                         zero;
  } mult_stage_t;

  typedef struct packed {
    logic signed [LPW_WIDTH-1:0]   lpw;
    logic signed [SHIFT_WIDTH-1:0] shift;
    logic                          zero;
  } lpw_stage_t;

  typedef struct packed {
    logic signed [SCALED_WIDTH-1:0] scaled;
    logic                           zero;
  } scaled_stage_t;

  range_reduced_t rr_d, rr_q;
  mult_stage_t    mult_d, mult_q;
  lpw_stage_t     lpw_d, lpw_q;
  scaled_stage_t  scaled_d, scaled_q;
  recip_t         recip_d;
  logic           rr_valid, rr_ready;
  logic           mult_valid, mult_ready;
  logic           lpw_valid, lpw_ready;
  logic           scaled_valid, scaled_ready;

  // Chord of 1/x between x1 and x2
  function automatic slope_t chord_slope(real x1, real x2);
    real m;
    m = (1.0 / x2 - 1.0 / x1) / (x2 - x1);
    return slope_t'(m * (2.0 ** SLOPE_FRAC_WIDTH));
  endfunction

  function automatic intercept_t chord_intercept(real x1, real x2);
    real m;
    real c;
    m = (1.0 / x2 - 1.0 / x1) / (x2 - x1);
    c = 1.0 / x1 - m * x1;
    return intercept_t'(c * (2.0 ** MULT_FRAC_WIDTH));
  endfunction

  slope_t     slope_lut     [ENTRIES];
  intercept_t intercept_lut [ENTRIES];

  initial begin
    real x1;
    real x2;
    for (int i = 0; i < ENTRIES; i++) begin
      x1 = 1.0 + real'(i) / ENTRIES;
      x2 = 1.0 + real'(i + 1) / ENTRIES;
      slope_lut[i]     = chord_slope(x1, x2);
      intercept_lut[i] = chord_intercept(x1, x2);
    end
  end

  fixed_range_reduction u_range_reduce (
    .data_in (in_data),
    .data_out(rr_d)
  );

  skid_buffer #(.DATA_WIDTH($bits(range_reduced_t))) u_rr_reg (
    .clk(clk), .reset(reset),
    .data_in(rr_d), .data_in_valid(in_valid), .data_in_ready(in_ready),
    .data_out(rr_q), .data_out_valid(rr_valid), .data_out_ready(rr_ready)
  );

  // Segment picked by the top fraction bits of the mantissa
  assign mult_d.seg  = rr_q.mant[MANT_FRAC_WIDTH-1 -: ENTRIES_WIDTH];
  assign mult_d.mult = $signed({1'b0, rr_q.mant}) * slope_lut[mult_d.seg];
  assign mult_d.msb  = rr_q.msb;
  assign mult_d.zero = rr_q.zero;

  skid_buffer #(.DATA_WIDTH($bits(mult_stage_t))) u_mult_reg (
    .clk(clk), .reset(reset),
    .data_in(mult_d), .data_in_valid(rr_valid), .data_in_ready(rr_ready),
    .data_out(mult_q), .data_out_valid(mult_valid), .data_out_ready(mult_ready)
  );

  assign lpw_d.lpw   = mult_q.mult + $signed({1'b0, intercept_lut[mult_q.seg]});
  // Undo the range reduction: 1/x scales by 2^(frac bits - msb)
  assign lpw_d.shift = SHIFT_WIDTH'(SUM_FRAC_WIDTH) - SHIFT_WIDTH'(mult_q.msb);
  assign lpw_d.zero  = mult_q.zero;

  skid_buffer #(.DATA_WIDTH($bits(lpw_stage_t))) u_lpw_reg (
    .clk(clk), .reset(reset),
    .data_in(lpw_d), .data_in_valid(mult_valid), .data_in_ready(mult_ready),
    .data_out(lpw_q), .data_out_valid(lpw_valid), .data_out_ready(lpw_ready)
  );

  always_comb begin
    logic signed [SCALED_WIDTH-1:0] lpw_ext;
    lpw_ext = SCALED_WIDTH'(lpw_q.lpw);
    if (lpw_q.shift >= 0) begin
      scaled_d.scaled = lpw_ext <<< lpw_q.shift;
    end else begin
      scaled_d.scaled = lpw_ext >>> (-lpw_q.shift);
    end
    scaled_d.zero = lpw_q.zero;
  end

  skid_buffer #(.DATA_WIDTH($bits(scaled_stage_t))) u_scaled_reg (
    .clk(clk), .reset(reset),
    .data_in(scaled_d), .data_in_valid(lpw_valid), .data_in_ready(lpw_ready),
    .data_out(scaled_q), .data_out_valid(scaled_valid), .data_out_ready(scaled_ready)
  );

  // Floor to Q1.7, saturate high and for 1/0
  always_comb begin
    logic signed [SCALED_WIDTH-1:0] floored;
    floored = scaled_q.scaled >>> (MULT_FRAC_WIDTH - RECIP_FRAC_WIDTH);
    if (scaled_q.zero || floored > RECIP_MAX) begin
      recip_d = '1;
    end else if (floored < 0) begin
      recip_d = '0;
    end else begin
      recip_d = floored[RECIP_WIDTH-1:0];
    end
  end

  skid_buffer #(.DATA_WIDTH(RECIP_WIDTH)) u_out_reg (
    .clk(clk), .reset(reset),
    .data_in(recip_d), .data_in_valid(scaled_valid), .data_in_ready(scaled_ready),
    .data_out(out_data), .data_out_valid(out_valid), .data_out_ready(out_ready)
  );

endmodule

/* logic/softermax_norm_top.sv */
// Softermax normalization back end
// Controller, element counter, datapath and reciprocal pipeline
`timescale 1ns/1ps

module softermax_norm_top import softermax_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  elem_t      in_data,
  input  logic       in_valid,
  output logic       in_ready,
  output norm_beat_t out_data,
  output logic       out_valid,
  input  logic       out_ready
);

  logic                 count_en;
  logic                 accept_elem;
  logic                 clear_sum;
  logic                 load_recip;
  logic [IDX_WIDTH-1:0] index;
  logic                 last;
  logic                 recip_in_valid;
  logic                 recip_in_ready;
  logic                 recip_out_valid;
  logic                 recip_out_ready;
  sum_t                 recip_in_data;
  recip_t               recip_out_data;

  norm_controller u_ctrl (.*);

  elem_counter u_counter (.*);

  norm_datapath u_datapath (.*);

  softermax_lpw_reciprocal #(.ENTRIES(8)) u_recip (
    .clk      (clk),
    .reset    (reset),
    .in_data  (recip_in_data),
    .in_valid (recip_in_valid),
    .in_ready (recip_in_ready),
    .out_data (recip_out_data),
    .out_valid(recip_out_valid),
    .out_ready(recip_out_ready)
  );

endmodule

/* logic/softermax_pkg.sv */
// Shared definitions for the softermax normalization back end
// Fixed-point widths for elements, sums, reciprocals and probabilities
// Internal widths of the piecewise-linear reciprocal
// Element, sum, reciprocal and probability types
// Controller state enum and the stream beat structs
package softermax_pkg;

  // Vector geometry
  localparam int VEC_LEN   = 4;
  localparam int IDX_WIDTH = $clog2(VEC_LEN);

  // Q4.4 input element, Q6.4 vector sum
  localparam int ELEM_WIDTH      = 8;
  localparam int ELEM_FRAC_WIDTH = 4;
  localparam int SUM_WIDTH       = 10;
  localparam int SUM_FRAC_WIDTH  = 4;

  // Q1.7 reciprocal and output probability
  localparam int RECIP_WIDTH      = 8;
  localparam int RECIP_FRAC_WIDTH = 7;
  localparam int RECIP_MAX        = 2 ** RECIP_WIDTH - 1;
  localparam int PROB_WIDTH       = 8;
  localparam int PROB_FRAC_WIDTH  = 7;
  localparam int PROB_MAX         = 2 ** PROB_WIDTH - 1;

  // Reciprocal internals, mantissa is Q1.9
  localparam int MANT_WIDTH       = SUM_WIDTH;
  localparam int MANT_FRAC_WIDTH  = SUM_WIDTH - 1;
  localparam int MSB_WIDTH        = $clog2(SUM_WIDTH);
  localparam int SHIFT_WIDTH      = MSB_WIDTH + 1;
  localparam int SLOPE_FRAC_WIDTH = RECIP_WIDTH;
  localparam int SLOPE_WIDTH      = SLOPE_FRAC_WIDTH + 1;
  localparam int MULT_WIDTH       = MANT_WIDTH + SLOPE_WIDTH;
  localparam int MULT_FRAC_WIDTH  = MANT_FRAC_WIDTH + SLOPE_FRAC_WIDTH;
  localparam int INTERCEPT_WIDTH  = MULT_FRAC_WIDTH + 2;
  localparam int LPW_WIDTH        = MULT_WIDTH + 1;
  // Headroom for shifting back by up to six integer bits
  localparam int SCALED_WIDTH     = LPW_WIDTH + 6;

  typedef logic [ELEM_WIDTH-1:0]  elem_t;
  typedef logic [SUM_WIDTH-1:0]   sum_t;
  typedef logic [RECIP_WIDTH-1:0] recip_t;
  typedef logic [PROB_WIDTH-1:0]  prob_t;

  typedef enum logic [1:0] {ACCUM, RECIP_REQ, RECIP_WAIT, SCALE} norm_state_e;

  typedef struct packed {
    logic [MANT_WIDTH-1:0] mant;
    logic [MSB_WIDTH-1:0]  msb;
    logic                  zero;
  } range_reduced_t;

  typedef struct packed {
    prob_t prob;
    logic  last;
  } norm_beat_t;

endpackage
